/* dual_issue.f */
isa_pkg.sv
issue_pkg.sv
inst_queue.sv
inst_predecode.sv
issue_select.sv
issue_csr.sv
issue_top.sv
issue_properties.sv
tb_issue_top.sv

/* inst_predecode.sv */
`timescale 1ns/1ps

module inst_predecode import isa_pkg::*; (
    input  logic [31:0] inst,
    output decoded_t    dec
);

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(inst[31:26]);
    assign funct  = funct_e'(inst[5:0]);

    always_comb begin
        dec.op_class  = other;
        dec.rs        = inst[25:21];
        dec.rt        = inst[20:16];
        dec.rd        = inst[15:11];
        dec.sa        = inst[10:6];
        dec.w_reg_ena = 1'b0;
        dec.w_reg_dst = 5'd0;
        dec.imme      = inst[15:0];
        dec.j_imme    = inst[25:0];

        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sll, fn_srl: begin
                        dec.op_class  = alu;
                        dec.w_reg_ena = 1'b1;
                        dec.w_reg_dst = inst[15:11];
                    end
                    fn_jr: begin
                        dec.op_class = jump_reg;
                    end
                    fn_mfhi, fn_mflo: begin
                        dec.op_class  = hilo;
                        dec.w_reg_ena = 1'b1;
                        dec.w_reg_dst = inst[15:11];
                    end
                    fn_mthi, fn_mtlo, fn_mult, fn_div: begin
                        dec.op_class = hilo;  // These only touch HI/LO.
                    end
                    default: begin
                        dec.op_class = other;
                    end
                endcase
            end
            op_addiu, op_slti, op_andi, op_ori, op_lui: begin
                dec.op_class  = alu_imm;
                dec.w_reg_ena = 1'b1;
                dec.w_reg_dst = inst[20:16];
            end
            op_lw, op_lb: begin
                dec.op_class  = load;
                dec.w_reg_ena = 1'b1;
                dec.w_reg_dst = inst[20:16];
            end
            op_sw, op_sb: begin
                dec.op_class = store;
            end
            op_beq, op_bne: begin
                dec.op_class = branch;
            end
            op_j: begin
                dec.op_class = jump;
            end
            op_jal: begin
                dec.op_class  = jump;
                dec.w_reg_ena = 1'b1;
                dec.w_reg_dst = 5'd31;  // Link register.
            end
            op_cop0: begin
                dec.op_class = cop0;
            end
            default: begin
                dec.op_class = other;
            end
        endcase
    end

endmodule

/* inst_queue.sv */
`timescale 1ns/1ps

module inst_queue import issue_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         push,
    input  queue_entry_t push_entry,
    input  logic         pop_1,
    input  logic         pop_2,
    output queue_entry_t head_1,
    output queue_entry_t head_2,
    output logic         head_1_ok,
    output logic         head_2_ok,
    output logic         full
);

    queue_entry_t         mem [QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr_plus_1;
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 push_ok;
    logic [PTR_WIDTH:0]   push_num;
    logic [PTR_WIDTH:0]   pop_num;

    assign rd_ptr_plus_1 = rd_ptr + 1'b1;
    assign head_1        = mem[rd_ptr];
    assign head_2        = mem[rd_ptr_plus_1];
    assign head_1_ok     = count != '0;
    assign head_2_ok     = count > (PTR_WIDTH+1)'(1);
    assign full          = count == (PTR_WIDTH+1)'(QUEUE_DEPTH);

    // Full is sampled before the pop, so a push into a full queue is lost.
    assign push_ok  = push && !full;
    assign push_num = {{PTR_WIDTH{1'b0}}, push_ok};

    always_comb begin
        if (pop_2 && head_2_ok) begin
            pop_num = (PTR_WIDTH+1)'(2);
        end else if (pop_1 && head_1_ok) begin
            pop_num = (PTR_WIDTH+1)'(1);
        end else begin
            pop_num = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + pop_num[PTR_WIDTH-1:0];  // Pointers wrap at the depth.
            wr_ptr <= wr_ptr + push_num[PTR_WIDTH-1:0];
            count  <= count + push_num - pop_num;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok && !flush) begin
            mem[wr_ptr] <= push_entry;
        end
    end

endmodule

/* isa_pkg.sv */
package isa_pkg;

    // Primary opcodes of the decoded subset.
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_cop0    = 6'h10,
        op_lb      = 6'h20,
        op_lw      = 6'h23,
        op_sb      = 6'h28,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_jr   = 6'h08,
        fn_mfhi = 6'h10,
        fn_mthi = 6'h11,
        fn_mflo = 6'h12,
        fn_mtlo = 6'h13,
        fn_mult = 6'h18,
        fn_div  = 6'h1a,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        alu, alu_imm, load, store, branch, jump, jump_reg, hilo, cop0, other
    } op_class_e;

    typedef struct packed {
        op_class_e   op_class;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic [15:0] imme;
        logic [25:0] j_imme;
    } decoded_t;

endpackage

/* issue_csr.sv */
`timescale 1ns/1ps

module issue_csr import issue_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        csr_we,
    input  csr_addr_e   csr_addr,
    input  logic [31:0] csr_wdata,
    input  logic        pop_1,
    input  logic        pop_2,
    output logic [31:0] csr_rdata,
    output logic        dual_enable
);

    logic [CNT_WIDTH-1:0] cnt [2];
    logic [1:0]           cnt_inc;
    logic [1:0]           cnt_clr;

    assign cnt_inc = {pop_2, pop_1};
    assign cnt_clr = {csr_we && (csr_addr == csr_cnt_2), csr_we && (csr_addr == csr_cnt_1)};

    always_ff @(posedge clk) begin
        if (rst) begin
            dual_enable <= 1'b1;  // Pairing is on out of reset.
        end else if (csr_we && (csr_addr == csr_ctrl)) begin
            dual_enable <= csr_wdata[0];
        end
    end

    // A clearing write takes priority over a same-cycle issue.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (rst || cnt_clr[i]) begin
                cnt[i] <= '0;
            end else if (cnt_inc[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    always_comb begin
        case (csr_addr)
            csr_ctrl:  csr_rdata = {31'd0, dual_enable};
            csr_cnt_1: csr_rdata = 32'(cnt[0]);
            csr_cnt_2: csr_rdata = 32'(cnt[1]);
            default:   csr_rdata = 32'd0;
        endcase
    end

endmodule

/* issue_pkg.sv */
package issue_pkg;

    import isa_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int PTR_WIDTH   = $clog2(QUEUE_DEPTH);
    localparam int CNT_WIDTH   = 32;  // Width of each issue counter.

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } queue_entry_t;

    // One issued instruction as handed to the decode stage.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        decoded_t    decoded;
        logic        in_delay_slot;
        logic        inst_adel;
    } issue_slot_t;

    typedef enum logic [1:0] {
        csr_ctrl  = 2'd0,
        csr_cnt_1 = 2'd1,
        csr_cnt_2 = 2'd2
    } csr_addr_e;

endpackage

/* issue_properties.sv */
`timescale 1ns/1ps

module issue_properties (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input logic        flush,
    input logic        pop_1,
    input logic        pop_2,
    input logic        head_1_ok,
    input logic [63:0] head_1,
    input logic [63:0] head_2
);

    // A single pop moves the younger entry up to the head.
    a_pop_order: assert property (@(posedge clk) disable iff (rst)
        pop_1 && !pop_2 && !flush |=> head_1 == $past(head_2))
        else $error("A single pop did not move the second entry to the head");

    a_stall_holds: assert property (@(posedge clk) disable iff (rst)
        stall && !flush && head_1_ok |=> head_1_ok && $stable(head_1))
        else $error("The queue head moved while stall was high");

    a_flush_empties: assert property (@(posedge clk) disable iff (rst) flush |=> !head_1_ok)
        else $error("The queue still held an entry one cycle after a flush");

endmodule

bind issue_top issue_properties u_properties (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .flush     (flush),
    .pop_1     (pop_1),
    .pop_2     (pop_2),
    .head_1_ok (head_1_ok),
    .head_1    (head_1),
    .head_2    (head_2)
);

/* issue_select.sv */
`timescale 1ns/1ps

module issue_select import isa_pkg::*, issue_pkg::*; (
    input  logic         stall,
    input  logic         dual_enable,
    input  queue_entry_t head_1,
    input  queue_entry_t head_2,
    input  logic         head_1_ok,
    input  logic         head_2_ok,
    input  decoded_t     dec_1,
    input  decoded_t     dec_2,
    output logic         pop_1,
    output logic         pop_2,
    output issue_slot_t  slot_1,
    output issue_slot_t  slot_2
);

    logic jmp_1;
    logic jmp_2;
    logic hilo_1;
    logic hilo_2;
    logic cop0_1;
    logic cop0_2;
    logic ls_1;
    logic ls_2;
    logic raw_hazard;
    logic pair_ok;

    assign jmp_1  = dec_1.op_class inside {branch, jump, jump_reg};
    assign jmp_2  = dec_2.op_class inside {branch, jump, jump_reg};
    assign hilo_1 = dec_1.op_class == hilo;
    assign hilo_2 = dec_2.op_class == hilo;
    assign cop0_1 = dec_1.op_class == cop0;
    assign cop0_2 = dec_2.op_class == cop0;
    assign ls_1   = dec_1.op_class inside {load, store};
    assign ls_2   = dec_2.op_class inside {load, store};

    // Writes to r0 are discarded, so they never create a dependency.
    assign raw_hazard = dec_1.w_reg_ena && (dec_1.w_reg_dst != 5'd0) &&
                        ((dec_1.w_reg_dst == dec_2.rs) || (dec_1.w_reg_dst == dec_2.rt));

    always_comb begin
        if (raw_hazard) begin
            pair_ok = 1'b0;
        end else if (jmp_1 || jmp_2) begin
            pair_ok = !jmp_2;  // A branch takes its delay slot along.
        end else if (hilo_1 || hilo_2) begin
            pair_ok = hilo_1 ^ hilo_2;
        end else if (cop0_1 || cop0_2) begin
            pair_ok = 1'b0;
        end else if (ls_1 || ls_2) begin
            pair_ok = ls_1 ^ ls_2;  // Only one memory port.
        end else begin
            pair_ok = 1'b1;
        end
    end

    // Waiting for two entries keeps a branch from leaving without its delay slot.
    assign pop_1 = !stall && head_1_ok && head_2_ok;
    assign pop_2 = pop_1 && dual_enable && pair_ok;

    assign slot_1.valid         = pop_1;
    assign slot_1.pc            = head_1.pc;
    assign slot_1.inst          = head_1.inst;
    assign slot_1.decoded       = dec_1;
    assign slot_1.in_delay_slot = 1'b0;
    assign slot_1.inst_adel     = head_1.pc[1:0] != 2'b00;

    assign slot_2.valid         = pop_2;
    assign slot_2.pc            = head_2.pc;
    assign slot_2.inst          = head_2.inst;
    assign slot_2.decoded       = dec_2;
    assign slot_2.in_delay_slot = jmp_1;
    assign slot_2.inst_adel     = head_2.pc[1:0] != 2'b00;

endmodule

/* issue_top.sv */
`timescale 1ns/1ps

module issue_top import isa_pkg::*, issue_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  logic         flush,
    input  logic         push,
    input  queue_entry_t push_entry,
    input  logic         csr_we,
    input  csr_addr_e    csr_addr,
    input  logic [31:0]  csr_wdata,
    output logic         full,
    output issue_slot_t  slot_1,
    output issue_slot_t  slot_2,
    output logic [31:0]  csr_rdata
);

    queue_entry_t head_1;
    queue_entry_t head_2;
    logic         head_1_ok;
    logic         head_2_ok;
    decoded_t     dec_1;
    decoded_t     dec_2;
    logic         pop_1;
    logic         pop_2;
    logic         dual_enable;

    inst_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (push),
        .push_entry (push_entry),
        .pop_1      (pop_1),
        .pop_2      (pop_2),
        .head_1     (head_1),
        .head_2     (head_2),
        .head_1_ok  (head_1_ok),
        .head_2_ok  (head_2_ok),
        .full       (full)
    );

    inst_predecode u_dec_1 (.inst(head_1.inst), .dec(dec_1));
    inst_predecode u_dec_2 (.inst(head_2.inst), .dec(dec_2));

    issue_select u_select (
        .stall       (stall),
        .dual_enable (dual_enable),
        .head_1      (head_1),
        .head_2      (head_2),
        .head_1_ok   (head_1_ok),
        .head_2_ok   (head_2_ok),
        .dec_1       (dec_1),
        .dec_2       (dec_2),
        .pop_1       (pop_1),
        .pop_2       (pop_2),
        .slot_1      (slot_1),
        .slot_2      (slot_2)
    );

    issue_csr u_csr (
        .clk         (clk),
        .rst         (rst),
        .csr_we      (csr_we),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .pop_1       (pop_1),
        .pop_2       (pop_2),
        .csr_rdata   (csr_rdata),
        .dual_enable (dual_enable)
    );

endmodule

/* run_sim.sh */
#!/bin/bash
# Build and run the issue stage testbench, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_issue_top -f dual_issue.f \
    -o sim_issue > build.log 2>&1 \
    && ./obj_dir/sim_issue > sim.log 2>&1
grep -q "^Test passed$" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* tb_issue_top.sv */
`timescale 1ns/1ps

module tb_issue_top import issue_pkg::*; ();

    localparam int NUM_ROWS        = 14;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 8 + 50;

    typedef struct packed {
        logic [31:0] inst_a;
        logic [31:0] pc_a;
        logic [31:0] inst_b;
        logic [31:0] pc_b;
        logic        push_b;   // Low leaves a single entry in the queue.
        logic        dual_en;
        logic        valid_1;
        logic        valid_2;
        logic        ds_2;
        logic        adel_1;
        logic        adel_2;
    } row_t;

    logic         clk;
    logic         rst;
    logic         stall;
    logic         flush;
    logic         push;
    queue_entry_t push_entry;
    logic         csr_we;
    csr_addr_e    csr_addr;
    logic [31:0]  csr_wdata;
    logic         full;
    issue_slot_t  slot_1;
    issue_slot_t  slot_2;
    logic [31:0]  csr_rdata;

    row_t  rows [NUM_ROWS];
    string names [NUM_ROWS];
    int    row_count;
    int    tally_1;
    int    tally_2;

    issue_top DUT (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .push(push),
        .push_entry(push_entry), .csr_we(csr_we), .csr_addr(csr_addr),
        .csr_wdata(csr_wdata), .full(full), .slot_1(slot_1), .slot_2(slot_2),
        .csr_rdata(csr_rdata)
    );

    always #10 clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $fatal(1, "Simulation stopped by the watchdog");
    end

    task automatic check_value(string test, string what, logic [31:0] expected,
                               logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s %s: expected %0h, actual %0h", test, what, expected, actual);
            $display("Test failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic add_row(string name, logic [31:0] inst_a, logic [31:0] pc_a,
                           logic [31:0] inst_b, logic [31:0] pc_b, logic [6:0] flags);
        rows[row_count]  = {inst_a, pc_a, inst_b, pc_b, flags};
        names[row_count] = name;
        row_count++;
    endtask

    // Flags are push_b, dual_en, valid_1, valid_2, ds_2, adel_1, adel_2.
    task automatic build_table();
        add_row("indep_alu",   32'h00222821, 32'h00001000, 32'h00643025, 32'h00001004,
                7'b11_11_000);
        add_row("raw_r5",      32'h00222821, 32'h00001000, 32'h00a33025, 32'h00001004,
                7'b11_10_000);
        add_row("r0_pair",     32'h00220021, 32'h00001000, 32'h00003025, 32'h00001004,
                7'b11_11_000);
        add_row("branch_alu",  32'h10220004, 32'h00002000, 32'h00643821, 32'h00002004,
                7'b11_11_100);
        add_row("alu_jump",    32'h00222821, 32'h00002000, 32'h08000100, 32'h00002004,
                7'b11_10_000);
        add_row("mult_mfhi",   32'h00220018, 32'h00003000, 32'h00004010, 32'h00003004,
                7'b11_10_000);
        add_row("lw_addu",     32'h8c290000, 32'h00003000, 32'h00435021, 32'h00003004,
                7'b11_11_000);
        add_row("lw_sw",       32'h8c290000, 32'h00004000, 32'hac4b0004, 32'h00004004,
                7'b11_10_000);
        add_row("cop0_first",  32'h40000000, 32'h00004000, 32'h00643821, 32'h00004004,
                7'b11_10_000);
        add_row("cop0_second", 32'h00643821, 32'h00005000, 32'h40000000, 32'h00005004,
                7'b11_10_000);
        add_row("single",      32'h00222821, 32'h00005000, 32'h00643025, 32'h00005004,
                7'b01_00_000);
        add_row("adel_1",      32'h00222821, 32'h00001002, 32'h00643025, 32'h00001008,
                7'b11_11_010);
        add_row("adel_2",      32'h00222821, 32'h00001000, 32'h00643025, 32'h0000100a,
                7'b11_11_001);
        add_row("dual_off",    32'h00222821, 32'h00006000, 32'h00643025, 32'h00006004,
                7'b10_10_000);
    endtask

    task automatic check_heads(int idx, string phase);
        check_value(names[idx], {phase, " pc_1"}, rows[idx].pc_a, slot_1.pc);
        check_value(names[idx], {phase, " inst_1"}, rows[idx].inst_a, slot_1.inst);
        if (rows[idx].push_b) begin
            check_value(names[idx], {phase, " pc_2"}, rows[idx].pc_b, slot_2.pc);
            check_value(names[idx], {phase, " inst_2"}, rows[idx].inst_b, slot_2.inst);
        end
    endtask

    task automatic apply_row(int idx);
        row_t r;
        r = rows[idx];
        @(posedge clk);
        stall     <= 1'b1;
        flush     <= 1'b1;
        csr_we    <= 1'b1;
        csr_addr  <= csr_ctrl;
        csr_wdata <= {31'd0, r.dual_en};
        @(posedge clk);
        flush      <= 1'b0;
        csr_we     <= 1'b0;
        push       <= 1'b1;
        push_entry <= '{pc: r.pc_a, inst: r.inst_a};
        @(posedge clk);
        push       <= r.push_b;
        push_entry <= '{pc: r.pc_b, inst: r.inst_b};
        @(posedge clk);
        push <= 1'b0;
        @(negedge clk);
        check_value(names[idx], "stalled valid_1", 32'd0, slot_1.valid);
        check_value(names[idx], "stalled valid_2", 32'd0, slot_2.valid);
        check_value(names[idx], "full", 32'd0, full);
        check_heads(idx, "stalled");
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        check_value(names[idx], "valid_1", r.valid_1, slot_1.valid);
        check_value(names[idx], "valid_2", r.valid_2, slot_2.valid);
        check_value(names[idx], "in_delay_slot_1", 32'd0, slot_1.in_delay_slot);
        check_value(names[idx], "adel_1", r.adel_1, slot_1.inst_adel);
        if (r.push_b) begin
            check_value(names[idx], "in_delay_slot_2", r.ds_2, slot_2.in_delay_slot);
            check_value(names[idx], "adel_2", r.adel_2, slot_2.inst_adel);
        end
        check_heads(idx, "issue");
        @(posedge clk);
        stall   <= 1'b1;  // The pops of this cycle land on this edge.
        tally_1 += r.valid_1;
        tally_2 += r.valid_2;
    endtask

    // Pushes one entry more than the depth, so the last push must be dropped.
    task automatic fill_queue();
        @(posedge clk);
        flush <= 1'b1;
        for (int i = 0; i <= QUEUE_DEPTH; i++) begin
            @(posedge clk);
            flush      <= 1'b0;
            push       <= 1'b1;
            push_entry <= '{pc: 32'h00007000 + 32'(4 * i), inst: 32'(i)};
        end
        @(posedge clk);
        push <= 1'b0;
        @(negedge clk);
        check_value("fill", "full", 32'd1, full);
        check_value("fill", "head pc", 32'h00007000, slot_1.pc);
    endtask

    task automatic read_csr(string what, csr_addr_e addr, logic [31:0] expected);
        @(posedge clk);
        csr_addr <= addr;
        @(negedge clk);
        check_value("csr_readback", what, expected, csr_rdata);
    endtask

    task automatic write_csr(csr_addr_e addr, logic [31:0] data);
        @(posedge clk);
        csr_we    <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= data;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        push       = 1'b0;
        push_entry = '0;
        csr_we     = 1'b0;
        csr_addr   = csr_ctrl;
        csr_wdata  = 32'd0;
        row_count  = 0;
        tally_1    = 0;
        tally_2    = 0;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        read_csr("ctrl after reset", csr_ctrl, 32'd1);
        check_value("reset", "valid_1", 32'd0, slot_1.valid);
        check_value("reset", "valid_2", 32'd0, slot_2.valid);
        for (int i = 0; i < row_count; i++) begin
            apply_row(i);
        end
        fill_queue();
        read_csr("ctrl", csr_ctrl, 32'd0);
        read_csr("cnt_1", csr_cnt_1, tally_1);
        read_csr("cnt_2", csr_cnt_2, tally_2);
        write_csr(csr_cnt_1, 32'd0);
        read_csr("cnt_1 cleared", csr_cnt_1, 32'd0);
        $display("Test passed");
        $finish;
    end

endmodule
